// ==== src/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;
    // 0 byte, 1 half, 2 word
    typedef logic [1:0]  size_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  mem_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_NOR  = 4'd6;
    localparam alu_op_t ALU_XOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;

    localparam mem_op_t MEM_NONE  = 4'd0;
    localparam mem_op_t MEM_LD_B  = 4'd1;
    localparam mem_op_t MEM_LD_BU = 4'd2;
    localparam mem_op_t MEM_LD_H  = 4'd3;
    localparam mem_op_t MEM_LD_HU = 4'd4;
    localparam mem_op_t MEM_LD_W  = 4'd5;
    localparam mem_op_t MEM_ST_B  = 4'd6;
    localparam mem_op_t MEM_ST_H  = 4'd7;
    localparam mem_op_t MEM_ST_W  = 4'd8;

    localparam int RAM_ADDR_BITS = 8;
    localparam int DIV_CYCLES    = 32;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire exe_pkg::alu_op_t alu_op,
    input  wire exe_pkg::word_t   alu_src1,
    input  wire exe_pkg::word_t   alu_src2,
    output exe_pkg::word_t        alu_result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = alu_src2[4:0];
    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    always_comb begin
        case (alu_op)
            exe_pkg::ALU_ADD:  alu_result = alu_src1 + alu_src2;
            exe_pkg::ALU_SUB:  alu_result = alu_src1 - alu_src2;
            exe_pkg::ALU_SLT:  alu_result = {31'b0, lt_signed};
            exe_pkg::ALU_SLTU: alu_result = {31'b0, lt_unsigned};
            exe_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            exe_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            exe_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            exe_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            exe_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            exe_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            exe_pkg::ALU_SRA:  alu_result = $signed(alu_src1) >>> shamt;
            // upper immediate comes in already shifted
            exe_pkg::ALU_LUI:  alu_result = alu_src2;
            default:           alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  wire                 clk,
    input  wire                 resetn,
    input  wire                 start,
    input  wire                 div_signed,
    input  wire exe_pkg::word_t dividend,
    input  wire exe_pkg::word_t divisor,
    output exe_pkg::word_t      quotient,
    output exe_pkg::word_t      remainder,
    output logic                done
);
    localparam int CNT_W = $clog2(exe_pkg::DIV_CYCLES);

    exe_pkg::div_state_t state;
    logic [CNT_W-1:0]    cnt;
    exe_pkg::word_t      quo_r;
    exe_pkg::word_t      rem_r;
    exe_pkg::word_t      dvs_r;
    logic                q_neg;
    logic                r_neg;
    logic [32:0]         shifted;
    logic [32:0]         diff;

    // one restoring step per cycle
    assign shifted = {rem_r, quo_r[31]};
    assign diff    = shifted - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= exe_pkg::DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exe_pkg::DIV_IDLE, exe_pkg::DIV_DONE: begin
                    if (start) begin
                        state <= exe_pkg::DIV_BUSY;
                        cnt   <= '0;
                    end
                end
                exe_pkg::DIV_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(exe_pkg::DIV_CYCLES - 1)) begin
                        state <= exe_pkg::DIV_DONE;
                    end
                end
                default: state <= exe_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state != exe_pkg::DIV_BUSY) begin
            quo_r <= (div_signed && dividend[31]) ? -dividend : dividend;
            dvs_r <= (div_signed && divisor[31]) ? -divisor : divisor;
            rem_r <= '0;
            q_neg <= div_signed & (dividend[31] ^ divisor[31]);
            r_neg <= div_signed & dividend[31];
        end else if (state == exe_pkg::DIV_BUSY) begin
            rem_r <= diff[32] ? shifted[31:0] : diff[31:0];
            quo_r <= {quo_r[30:0], ~diff[32]};
        end
    end

    // remainder follows the dividend sign
    assign quotient  = q_neg ? -quo_r : quo_r;
    assign remainder = r_neg ? -rem_r : rem_r;
    assign done      = state == exe_pkg::DIV_DONE;

    no_start_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        start |-> state != exe_pkg::DIV_BUSY);

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  wire                     clk,
    input  wire                     resetn,
    // decode side
    input  wire                     in_valid,
    output logic                    in_allowin,
    input  wire exe_pkg::word_t     in_pc,
    input  wire exe_pkg::alu_op_t   in_alu_op,
    input  wire exe_pkg::word_t     in_src1,
    input  wire exe_pkg::word_t     in_src2,
    input  wire exe_pkg::word_t     in_store_data,
    input  wire exe_pkg::mem_op_t   in_mem_op,
    input  wire                     in_div,
    input  wire                     in_div_signed,
    input  wire                     in_div_rem,
    input  wire                     in_rf_we,
    input  wire exe_pkg::reg_addr_t in_rf_waddr,
    // memory stage
    input  wire                     mem_allowin,
    output logic                    ex_to_mem_valid,
    output exe_pkg::word_t          mem_pc,
    output logic                    mem_rf_we,
    output exe_pkg::reg_addr_t      mem_rf_waddr,
    output exe_pkg::word_t          mem_result,
    output exe_pkg::mem_op_t        mem_op,
    output logic                    mem_excp_ale,
    // data ram
    output logic                    data_req,
    output logic                    data_wr,
    output exe_pkg::size_t          data_size,
    output exe_pkg::strb_t          data_wstrb,
    output exe_pkg::word_t          data_addr,
    output exe_pkg::word_t          data_wdata,
    input  wire                     data_addr_ok
);
    logic               ex_valid;
    logic               ready_go;
    exe_pkg::word_t     op_pc;
    exe_pkg::alu_op_t   op_alu_op;
    exe_pkg::word_t     op_src1;
    exe_pkg::word_t     op_src2;
    exe_pkg::word_t     op_store_data;
    exe_pkg::mem_op_t   op_mem_op;
    logic               op_div;
    logic               op_div_signed;
    logic               op_div_rem;
    logic               op_rf_we;
    exe_pkg::reg_addr_t op_rf_waddr;
    exe_pkg::word_t     alu_result;
    exe_pkg::word_t     quotient;
    exe_pkg::word_t     remainder;
    logic               div_start;
    logic               div_done;
    logic               div_started;
    logic               is_load;
    logic               is_store;
    logic               excp_ale;
    logic               mem_wait;
    exe_pkg::strb_t     st_strb;

    assign ready_go        = (data_req & data_addr_ok) |
                             (op_div & div_started & div_done) |
                             ~(mem_wait | op_div);
    assign in_allowin      = ~ex_valid | (ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_pc         <= in_pc;
            op_alu_op     <= in_alu_op;
            op_src1       <= in_src1;
            op_src2       <= in_src2;
            op_store_data <= in_store_data;
            op_mem_op     <= in_mem_op;
            op_div        <= in_div;
            op_div_signed <= in_div_signed;
            op_div_rem    <= in_div_rem;
            op_rf_we      <= in_rf_we;
            op_rf_waddr   <= in_rf_waddr;
        end
    end

    alu u_alu (
        .alu_op     (op_alu_op),
        .alu_src1   (op_src1),
        .alu_src2   (op_src2),
        .alu_result (alu_result)
    );

    // divider is kicked once per operation
    assign div_start = ex_valid & op_div & ~div_started;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_started <= 1'b0;
        end else if (in_valid && in_allowin) begin
            div_started <= 1'b0;
        end else if (div_start) begin
            div_started <= 1'b1;
        end
    end

    div_unit u_div (
        .clk        (clk),
        .resetn     (resetn),
        .start      (div_start),
        .div_signed (op_div_signed),
        .dividend   (op_src1),
        .divisor    (op_src2),
        .quotient   (quotient),
        .remainder  (remainder),
        .done       (div_done)
    );

    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        data_size = 2'd2;
        case (op_mem_op)
            exe_pkg::MEM_LD_B, exe_pkg::MEM_LD_BU: begin
                is_load   = 1'b1;
                data_size = 2'd0;
            end
            exe_pkg::MEM_LD_H, exe_pkg::MEM_LD_HU: begin
                is_load   = 1'b1;
                data_size = 2'd1;
            end
            exe_pkg::MEM_LD_W: is_load = 1'b1;
            exe_pkg::MEM_ST_B: begin
                is_store  = 1'b1;
                data_size = 2'd0;
            end
            exe_pkg::MEM_ST_H: begin
                is_store  = 1'b1;
                data_size = 2'd1;
            end
            exe_pkg::MEM_ST_W: is_store = 1'b1;
            default: data_size = 2'd2;
        endcase
    end

    assign excp_ale = ex_valid & (is_load | is_store) &
                      ((data_size == 2'd1 & alu_result[0]) |
                       (data_size == 2'd2 & |alu_result[1:0]));
    assign mem_wait = ex_valid & (is_load | is_store) & ~excp_ale;

    always_comb begin
        case (data_size)
            2'd0:    st_strb = 4'b0001 << alu_result[1:0];
            2'd1:    st_strb = alu_result[1] ? 4'b1100 : 4'b0011;
            default: st_strb = 4'b1111;
        endcase
    end

    assign data_req   = mem_wait & mem_allowin;
    assign data_wr    = is_store;
    assign data_wstrb = is_store ? st_strb : 4'b0000;
    assign data_addr  = alu_result;
    assign data_wdata = (data_size == 2'd0) ? {4{op_store_data[7:0]}} :
                        (data_size == 2'd1) ? {2{op_store_data[15:0]}} :
                        op_store_data;

    assign mem_pc       = op_pc;
    assign mem_rf_we    = op_rf_we & ~excp_ale;
    assign mem_rf_waddr = op_rf_waddr;
    assign mem_result   = op_div ? (op_div_rem ? remainder : quotient) : alu_result;
    assign mem_op       = op_mem_op;
    assign mem_excp_ale = excp_ale;

    // stalled record must not drift while memory stage is full
    hold_while_blocked: assert property (@(posedge clk) disable iff (!resetn)
        ex_to_mem_valid && !mem_allowin |=>
            ex_to_mem_valid && $stable(mem_pc) && $stable(mem_result) &&
            $stable(mem_rf_we) && $stable(mem_rf_waddr));

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input  wire                 clk,
    input  wire                 data_req,
    input  wire                 data_wr,
    input  wire exe_pkg::size_t data_size,
    input  wire exe_pkg::strb_t data_wstrb,
    input  wire exe_pkg::word_t data_addr,
    input  wire exe_pkg::word_t data_wdata,
    output logic                data_addr_ok,
    output exe_pkg::word_t      data_rdata
);
    localparam int DEPTH = 2 ** exe_pkg::RAM_ADDR_BITS;

    exe_pkg::word_t                    mem [DEPTH];
    logic [exe_pkg::RAM_ADDR_BITS-1:0] idx;

    // always ready to take a request
    assign data_addr_ok = 1'b1;
    assign idx          = data_addr[exe_pkg::RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (data_req && data_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (data_wstrb[i]) begin
                    mem[idx][8*i +: 8] <= data_wdata[8*i +: 8];
                end
            end
        end
        if (data_req && !data_wr) begin
            data_rdata <= mem[idx];
        end
    end

    word_aligned: assert property (@(posedge clk)
        data_req && data_size == 2'd2 |-> data_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     ex_to_mem_valid,
    output logic                    mem_allowin,
    input  wire exe_pkg::word_t     mem_pc,
    input  wire                     mem_rf_we,
    input  wire exe_pkg::reg_addr_t mem_rf_waddr,
    input  wire exe_pkg::word_t     mem_result,
    input  wire exe_pkg::mem_op_t   mem_op,
    input  wire                     mem_excp_ale,
    input  wire exe_pkg::word_t     data_rdata,
    input  wire                     out_ready,
    output logic                    wb_valid,
    output exe_pkg::word_t          wb_pc,
    output logic                    wb_rf_we,
    output exe_pkg::reg_addr_t      wb_rf_waddr,
    output exe_pkg::word_t          wb_rf_wdata,
    output logic                    wb_excp_ale
);
    exe_pkg::word_t   result_r;
    exe_pkg::mem_op_t op_r;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;

    assign mem_allowin = ~wb_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (mem_allowin) begin
            wb_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            wb_pc       <= mem_pc;
            wb_rf_we    <= mem_rf_we;
            wb_rf_waddr <= mem_rf_waddr;
            wb_excp_ale <= mem_excp_ale;
            result_r    <= mem_result;
            op_r        <= mem_op;
        end
    end

    // low address bits pick the lane
    assign ld_byte = data_rdata[{result_r[1:0], 3'b000} +: 8];
    assign ld_half = result_r[1] ? data_rdata[31:16] : data_rdata[15:0];

    always_comb begin
        wb_rf_wdata = result_r;
        if (!wb_excp_ale) begin
            case (op_r)
                exe_pkg::MEM_LD_B:  wb_rf_wdata = {{24{ld_byte[7]}}, ld_byte};
                exe_pkg::MEM_LD_BU: wb_rf_wdata = {24'b0, ld_byte};
                exe_pkg::MEM_LD_H:  wb_rf_wdata = {{16{ld_half[15]}}, ld_half};
                exe_pkg::MEM_LD_HU: wb_rf_wdata = {16'b0, ld_half};
                exe_pkg::MEM_LD_W:  wb_rf_wdata = data_rdata;
                default:            wb_rf_wdata = result_r;
            endcase
        end
    end

    // load data relies on the ram holding rdata during a stall
    wb_hold: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && !out_ready |=>
            wb_valid && $stable(wb_pc) && $stable(wb_rf_we) && $stable(wb_rf_waddr) &&
            $stable(wb_rf_wdata) && $stable(wb_excp_ale));

endmodule

`default_nettype wire

// ==== src/exe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     in_valid,
    output logic                    in_allowin,
    input  wire exe_pkg::word_t     in_pc,
    input  wire exe_pkg::alu_op_t   in_alu_op,
    input  wire exe_pkg::word_t     in_src1,
    input  wire exe_pkg::word_t     in_src2,
    input  wire exe_pkg::word_t     in_store_data,
    input  wire exe_pkg::mem_op_t   in_mem_op,
    input  wire                     in_div,
    input  wire                     in_div_signed,
    input  wire                     in_div_rem,
    input  wire                     in_rf_we,
    input  wire exe_pkg::reg_addr_t in_rf_waddr,
    input  wire                     out_ready,
    output logic                    wb_valid,
    output exe_pkg::word_t          wb_pc,
    output logic                    wb_rf_we,
    output exe_pkg::reg_addr_t      wb_rf_waddr,
    output exe_pkg::word_t          wb_rf_wdata,
    output logic                    wb_excp_ale
);
    logic               mem_allowin;
    logic               ex_to_mem_valid;
    exe_pkg::word_t     mem_pc;
    logic               mem_rf_we;
    exe_pkg::reg_addr_t mem_rf_waddr;
    exe_pkg::word_t     mem_result;
    exe_pkg::mem_op_t   mem_op;
    logic               mem_excp_ale;
    logic               data_req;
    logic               data_wr;
    exe_pkg::size_t     data_size;
    exe_pkg::strb_t     data_wstrb;
    exe_pkg::word_t     data_addr;
    exe_pkg::word_t     data_wdata;
    logic               data_addr_ok;
    exe_pkg::word_t     data_rdata;

    ex_stage u_ex (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_pc           (in_pc),
        .in_alu_op       (in_alu_op),
        .in_src1         (in_src1),
        .in_src2         (in_src2),
        .in_store_data   (in_store_data),
        .in_mem_op       (in_mem_op),
        .in_div          (in_div),
        .in_div_signed   (in_div_signed),
        .in_div_rem      (in_div_rem),
        .in_rf_we        (in_rf_we),
        .in_rf_waddr     (in_rf_waddr),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .mem_pc          (mem_pc),
        .mem_rf_we       (mem_rf_we),
        .mem_rf_waddr    (mem_rf_waddr),
        .mem_result      (mem_result),
        .mem_op          (mem_op),
        .mem_excp_ale    (mem_excp_ale),
        .data_req        (data_req),
        .data_wr         (data_wr),
        .data_size       (data_size),
        .data_wstrb      (data_wstrb),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .data_addr_ok    (data_addr_ok)
    );

    data_ram u_ram (
        .clk          (clk),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .data_rdata   (data_rdata)
    );

    mem_stage u_mem (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .mem_allowin     (mem_allowin),
        .mem_pc          (mem_pc),
        .mem_rf_we       (mem_rf_we),
        .mem_rf_waddr    (mem_rf_waddr),
        .mem_result      (mem_result),
        .mem_op          (mem_op),
        .mem_excp_ale    (mem_excp_ale),
        .data_rdata      (data_rdata),
        .out_ready       (out_ready),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_excp_ale     (wb_excp_ale)
    );

endmodule

`default_nettype wire

// ==== tb/exe_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_checker (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     in_valid,
    input  wire                     in_allowin,
    input  wire                     wb_valid,
    input  wire                     out_ready,
    input  wire exe_pkg::word_t     wb_pc,
    input  wire                     wb_rf_we,
    input  wire exe_pkg::reg_addr_t wb_rf_waddr,
    input  wire exe_pkg::word_t     wb_rf_wdata,
    input  wire                     wb_excp_ale
);
    exe_pkg::word_t     exp_pc_q[$];
    logic               exp_we_q[$];
    exe_pkg::reg_addr_t exp_waddr_q[$];
    exe_pkg::word_t     exp_wdata_q[$];
    logic               exp_ale_q[$];
    logic               first_q[$];
    int                 errors = 0;
    int                 checked = 0;
    logic               held = 1'b0;
    logic               fresh = 1'b1;
    logic               want_first;
    exe_pkg::word_t     held_pc;
    exe_pkg::word_t     held_wdata;
    logic [6:0]         held_ctrl;

    task automatic expect_wb(input exe_pkg::word_t pc, input logic we,
                             input exe_pkg::reg_addr_t waddr, input exe_pkg::word_t wdata,
                             input logic ale);
        exp_pc_q.push_back(pc);
        exp_we_q.push_back(we);
        exp_waddr_q.push_back(waddr);
        exp_wdata_q.push_back(wdata);
        exp_ale_q.push_back(ale);
    endtask

    task automatic expect_accept(input logic first);
        first_q.push_back(first);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // sampled mid-cycle, an accept here retires on the next rising edge
    always @(negedge clk) begin
        if (!resetn) begin
            held  = 1'b0;
            fresh = 1'b1;
        end else begin
            // first cycle an operation is offered
            if (in_valid) begin
                if (fresh && first_q.size() != 0) begin
                    want_first = first_q.pop_front();
                    if (want_first) begin
                        compare("in_allowin", 32'd1, {31'b0, in_allowin});
                    end
                end
                fresh = in_allowin;
            end
            if (held) begin
                compare("wb_valid (stalled)", 32'd1, {31'b0, wb_valid});
                compare("wb_pc (stalled)", held_pc, wb_pc);
                compare("wb_rf_wdata (stalled)", held_wdata, wb_rf_wdata);
                compare("wb_rf_we/waddr/ale (stalled)", {25'b0, held_ctrl},
                        {25'b0, wb_rf_we, wb_rf_waddr, wb_excp_ale});
            end
            held       = wb_valid && !out_ready;
            held_pc    = wb_pc;
            held_wdata = wb_rf_wdata;
            held_ctrl  = {wb_rf_we, wb_rf_waddr, wb_excp_ale};
            if (wb_valid && out_ready) begin
                if (exp_pc_q.size() == 0) begin
                    errors++;
                    $display("extra writeback at %0t from pc %h, no operation left to match",
                             $time, wb_pc);
                end else begin
                    compare("wb_pc", exp_pc_q.pop_front(), wb_pc);
                    compare("wb_rf_we", {31'b0, exp_we_q.pop_front()}, {31'b0, wb_rf_we});
                    compare("wb_rf_waddr", {27'b0, exp_waddr_q.pop_front()},
                            {27'b0, wb_rf_waddr});
                    compare("wb_rf_wdata", exp_wdata_q.pop_front(), wb_rf_wdata);
                    compare("wb_excp_ale", {31'b0, exp_ale_q.pop_front()},
                            {31'b0, wb_excp_ale});
                    checked++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_exe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exe_top;
    localparam int MAX_OPS         = 64;
    localparam int ALLOWIN_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT   = 500;

    logic               clk;
    logic               resetn;
    logic               in_valid;
    logic               in_allowin;
    exe_pkg::word_t     in_pc;
    exe_pkg::alu_op_t   in_alu_op;
    exe_pkg::word_t     in_src1;
    exe_pkg::word_t     in_src2;
    exe_pkg::word_t     in_store_data;
    exe_pkg::mem_op_t   in_mem_op;
    logic               in_div;
    logic               in_div_signed;
    logic               in_div_rem;
    logic               in_rf_we;
    exe_pkg::reg_addr_t in_rf_waddr;
    logic               out_ready;
    logic               wb_valid;
    exe_pkg::word_t     wb_pc;
    logic               wb_rf_we;
    exe_pkg::reg_addr_t wb_rf_waddr;
    exe_pkg::word_t     wb_rf_wdata;
    logic               wb_excp_ale;

    // one row per operation, columns as in the trace file
    logic [31:0] tr [0:MAX_OPS-1][0:15];
    int          n_ops;
    int          tb_errors;
    int          wb_idx;
    int          stall_left;
    logic        taken;
    logic        stalled;
    logic        aborted;

    exe_top u_dut (
        .clk (clk), .resetn (resetn), .in_valid (in_valid), .in_allowin (in_allowin),
        .in_pc (in_pc), .in_alu_op (in_alu_op), .in_src1 (in_src1), .in_src2 (in_src2),
        .in_store_data (in_store_data), .in_mem_op (in_mem_op), .in_div (in_div),
        .in_div_signed (in_div_signed), .in_div_rem (in_div_rem), .in_rf_we (in_rf_we),
        .in_rf_waddr (in_rf_waddr), .out_ready (out_ready), .wb_valid (wb_valid),
        .wb_pc (wb_pc), .wb_rf_we (wb_rf_we), .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata), .wb_excp_ale (wb_excp_ale)
    );

    exe_checker u_chk (
        .clk (clk), .resetn (resetn), .in_valid (in_valid), .in_allowin (in_allowin),
        .wb_valid (wb_valid), .out_ready (out_ready),
        .wb_pc (wb_pc), .wb_rf_we (wb_rf_we), .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata), .wb_excp_ale (wb_excp_ale)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // stall column says how long each writeback is held off
    always begin
        @(negedge clk);
        taken   = wb_valid && out_ready;
        stalled = wb_valid && !out_ready;
        @(posedge clk);
        #1;
        if (taken) begin
            wb_idx++;
            stall_left = (wb_idx < n_ops) ? int'(tr[wb_idx][0]) : 0;
        end else if (stalled && stall_left > 0) begin
            stall_left--;
        end
        out_ready = (stall_left == 0);
    end

    task automatic load_trace();
        int               fd;
        int               cnt;
        logic [8*256-1:0] line;
        fd = $fopen("tb/exe_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file tb/exe_trace.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                // header and blank lines do not scan
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              tr[n_ops][0], tr[n_ops][1], tr[n_ops][2], tr[n_ops][3],
                              tr[n_ops][4], tr[n_ops][5], tr[n_ops][6], tr[n_ops][7],
                              tr[n_ops][8], tr[n_ops][9], tr[n_ops][10], tr[n_ops][11],
                              tr[n_ops][12], tr[n_ops][13], tr[n_ops][14], tr[n_ops][15]);
                if (cnt == 16) begin
                    n_ops++;
                end
            end
        end
        $fclose(fd);
        if (n_ops == 0) begin
            $display("trace file holds no operations");
            tb_errors++;
        end
    endtask

    // divide just ahead or stalled writeback two ahead delays acceptance
    function automatic logic accept_at_once(input int i);
        logic first;
        first = 1'b1;
        if (i > 0) begin
            if (tr[i-1][7][0]) begin
                first = 1'b0;
            end
        end
        if (i > 1) begin
            if (tr[i-2][0] != 0) begin
                first = 1'b0;
            end
        end
        return first;
    endfunction

    task automatic send_op(input int i);
        int   cyc;
        logic accepted;
        in_valid      = 1'b1;
        in_pc         = tr[i][1];
        in_alu_op     = tr[i][2][3:0];
        in_src1       = tr[i][3];
        in_src2       = tr[i][4];
        in_store_data = tr[i][5];
        in_mem_op     = tr[i][6][3:0];
        in_div        = tr[i][7][0];
        in_div_signed = tr[i][8][0];
        in_div_rem    = tr[i][9][0];
        in_rf_we      = tr[i][10][0];
        in_rf_waddr   = tr[i][11][4:0];
        accepted = 1'b0;
        cyc      = 0;
        while (!accepted && cyc < ALLOWIN_TIMEOUT) begin
            @(negedge clk);
            accepted = in_allowin;
            @(posedge clk);
            #1;
            cyc++;
        end
        in_valid = 1'b0;
        if (!accepted) begin
            $display("timeout: operation %0d at pc %h was not accepted within %0d cycles",
                     i, tr[i][1], ALLOWIN_TIMEOUT);
            tb_errors++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int cyc;
        resetn        = 1'b0;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_alu_op     = '0;
        in_src1       = '0;
        in_src2       = '0;
        in_store_data = '0;
        in_mem_op     = '0;
        in_div        = 1'b0;
        in_div_signed = 1'b0;
        in_div_rem    = 1'b0;
        in_rf_we      = 1'b0;
        in_rf_waddr   = '0;
        out_ready     = 1'b0;
        n_ops         = 0;
        tb_errors     = 0;
        wb_idx        = 0;
        stall_left    = 0;
        aborted       = 1'b0;
        load_trace();
        if (n_ops > 0) begin
            stall_left = tr[0][0];
        end
        for (int i = 0; i < n_ops; i++) begin
            u_chk.expect_wb(tr[i][1], tr[i][12][0], tr[i][13][4:0], tr[i][14], tr[i][15][0]);
            u_chk.expect_accept(accept_at_once(i));
        end
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int i = 0; i < n_ops && !aborted; i++) begin
            send_op(i);
        end
        cyc = 0;
        while (!aborted && u_chk.checked < n_ops && cyc < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (!aborted && u_chk.checked < n_ops) begin
            $display("timeout: only %0d of %0d writebacks arrived within %0d cycles",
                     u_chk.checked, n_ops, DRAIN_TIMEOUT);
            tb_errors++;
        end
        // a few idle cycles so a duplicated writeback still shows up
        repeat (5) @(posedge clk);
        $display("checked %0d of %0d writebacks, %0d checker errors, %0d testbench errors",
                 u_chk.checked, n_ops, u_chk.errors, tb_errors);
        if (u_chk.errors == 0 && tb_errors == 0 && u_chk.checked == n_ops) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/exe_trace.txt ====
# stall pc alu_op src1 src2 store_data mem_op div signed rem rf_we rf_waddr, all hex
# then expected wb_rf_we wb_rf_waddr wb_rf_wdata wb_excp_ale
0 1c000000 0 00000005 00000007 00000000 0 0 0 0 1 01 1 01 0000000c 0
3 1c000004 1 00000003 00000005 00000000 0 0 0 0 1 02 1 02 fffffffe 0
0 1c000008 2 fffffffe 00000001 00000000 0 0 0 0 1 03 1 03 00000001 0
0 1c00000c 3 fffffffe 00000001 00000000 0 0 0 0 1 04 1 04 00000000 0
0 1c000010 4 f0f0f0f0 0ff00ff0 00000000 0 0 0 0 1 05 1 05 00f000f0 0
0 1c000014 5 f0f0f0f0 0ff00ff0 00000000 0 0 0 0 1 06 1 06 fff0fff0 0
0 1c000018 6 12340000 00005678 00000000 0 0 0 0 1 07 1 07 edcba987 0
0 1c00001c 7 ffff0000 0f0f0f0f 00000000 0 0 0 0 1 08 1 08 f0f00f0f 0
0 1c000020 8 00000001 00000024 00000000 0 0 0 0 1 09 1 09 00000010 0
0 1c000024 9 80000000 0000001f 00000000 0 0 0 0 1 0a 1 0a 00000001 0
0 1c000028 a 80000000 00000004 00000000 0 0 0 0 1 0b 1 0b f8000000 0
0 1c00002c b 00000000 abcd0000 00000000 0 0 0 0 1 0c 1 0c abcd0000 0
0 1c000030 0 fffffff9 00000002 00000000 0 1 1 0 1 0d 1 0d fffffffd 0
2 1c000034 0 fffffff9 00000002 00000000 0 1 1 1 1 0e 1 0e ffffffff 0
0 1c000038 0 fffffff9 00000002 00000000 0 1 0 0 1 0f 1 0f 7ffffffc 0
0 1c00003c 0 00000064 00000007 00000000 0 1 0 1 1 10 1 10 00000002 0
0 1c000040 0 00000007 fffffffe 00000000 0 1 1 1 1 18 1 18 00000001 0
1 1c000044 0 00000100 00000000 8899aabb 8 0 0 0 0 00 0 00 00000100 0
0 1c000048 0 00000100 00000001 000000cc 6 0 0 0 0 00 0 00 00000101 0
0 1c00004c 0 00000100 00000002 1234f00d 7 0 0 0 0 00 0 00 00000102 0
0 1c000050 0 00000100 00000001 00000000 1 0 0 0 1 11 1 11 ffffffcc 0
0 1c000054 0 00000100 00000001 00000000 2 0 0 0 1 12 1 12 000000cc 0
4 1c000058 0 00000100 00000002 00000000 3 0 0 0 1 13 1 13 fffff00d 0
0 1c00005c 0 00000100 00000002 00000000 4 0 0 0 1 14 1 14 0000f00d 0
0 1c000060 0 00000100 00000000 00000000 5 0 0 0 1 15 1 15 f00dccbb 0
0 1c000064 0 00000100 00000002 deadbeef 8 0 0 0 0 00 0 00 00000102 1
0 1c000068 0 00000100 00000001 00000000 3 0 0 0 1 16 0 16 00000101 1
0 1c00006c 0 00000100 00000003 0000dead 7 0 0 0 0 00 0 00 00000103 1
5 1c000070 0 00000100 00000000 00000000 5 0 0 0 1 17 1 17 f00dccbb 0
0 1c000074 0 00000100 00000003 00000000 2 0 0 0 1 19 1 19 000000f0 0

// ==== src.f ====
src/exe_pkg.sv
src/alu.sv
src/div_unit.sv
src/ex_stage.sv
src/data_ram.sv
src/mem_stage.sv
src/exe_top.sv
tb/exe_checker.sv
tb/tb_exe_top.sv
